//--- sim/dma_fe_testdata.txt
// kind 0 instr: op arga argb tag | 5 instr that must stall, then holds drop
// kind 1 resp: data tag flag(0 literal, 1 jobs done, 2 busy) 0 | 2 burst: src dst len 0
// kind 3 holds: burst res 0 0 | 4 wait until quiet | f end of records
0 0 10000000 12 0
0 1 20000000 34 0
0 2 100 0 3
1 0 3 0 0
2 1210000000 3420000000 100 0
0 2 40 0 4
1 1 4 0 0
2 1210000000 3420000000 40 0
// 2D copy, three strided bursts
0 4 100 200 5
0 5 3 0 6
0 20000a 80 0 7
1 2 7 0 0
2 1210000000 3420000000 80 0
2 1210000100 3420000200 80 0
2 1210000200 3420000400 80 0
4 0 0 0 0
0 b 0 0 8
1 0 8 1 0
0 10000b 0 0 9
1 3 9 0 0
0 20000b 0 0 a
1 0 a 0 0
// backend held, queue fills up
3 1 0 0 0
0 2 10 0 b
1 3 b 0 0
2 1210000000 3420000000 10 0
0 20000b 0 0 c
1 1 c 2 0
0 2 20 0 d
1 4 d 0 0
2 1210000000 3420000000 20 0
0 2 30 0 e
1 5 e 0 0
2 1210000000 3420000000 30 0
0 2 40 0 f
1 6 f 0 0
2 1210000000 3420000000 40 0
0 30000b 0 0 10
1 1 10 0 0
5 2 50 0 11
1 7 11 0 0
2 1210000000 3420000000 50 0
4 0 0 0 0
0 20000b 0 0 12
1 0 12 0 0
0 b 0 0 13
1 8 13 1 0
// response path held
3 0 1 0 0
0 10000b 0 0 14
1 8 14 0 0
0 10000b 0 0 15
1 8 15 0 0
5 10000b 0 0 16
1 8 16 0 0
f 0 0 0 0

//--- src.f
+incdir+design
design/dma_fe_pkg.sv
design/dma_inst_decode.sv
design/dma_req_fifo.sv
design/dma_twod_midend.sv
design/dma_transfer_id_gen.sv
design/dma_resp_spill.sv
design/dma_fe_top.sv
sim/tb_dma_fe.sv

//--- Bender.yml
package:
  name: dma_fe

sources:
  - include_dirs:
      - design
    files:
      - design/dma_fe_pkg.sv
      - design/dma_inst_decode.sv
      - design/dma_req_fifo.sv
      - design/dma_twod_midend.sv
      - design/dma_transfer_id_gen.sv
      - design/dma_resp_spill.sv
      - design/dma_fe_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_dma_fe.sv

//--- sim/tb_dma_fe.sv
// self-checking testbench of the DMA frontend
// replays records from the testdata file, models the burst backend and checks
// responses and bursts in order against the expected records
`timescale 1ns/1ps
`default_nettype none

`include "dma_fe_macros.svh"

module tb_dma_fe;

    localparam int MAX_REC = 64;
    localparam int REC_W   = 5;

    logic                  clk_i, arst_n_i;
    dma_fe_pkg::instr_t    acc_op_i;
    dma_fe_pkg::acc_data_t acc_arga_i, acc_argb_i, acc_res_data_o;
    dma_fe_pkg::acc_id_t   acc_id_i, acc_res_id_o;
    logic                  acc_valid_i, acc_ready_o, acc_res_valid_o, acc_res_ready_i;
    dma_fe_pkg::addr_t     burst_src_o, burst_dst_o;
    dma_fe_pkg::len_t      burst_len_o;
    logic                  burst_valid_o, burst_ready_i, burst_done_i, busy_o;

    logic [63:0]           recs [0:MAX_REC*REC_W-1];
    int                    n_rec;
    integer                seed;
    logic                  hold_burst, hold_res;
    // expected traffic and backend bookkeeping
    dma_fe_pkg::acc_data_t exp_data_q [$];
    dma_fe_pkg::acc_id_t   exp_id_q [$];
    dma_fe_pkg::addr_t     exp_src_q [$], exp_dst_q [$];
    dma_fe_pkg::len_t      exp_len_q [$];
    int                    job_bursts_q [$];
    int                    owed, done_wait, job_done_cnt, jobs_done, launched;
    dma_fe_pkg::rep_t      model_reps;

    dma_fe_top DUT (
        .clk_i, .arst_n_i, .acc_op_i, .acc_arga_i, .acc_argb_i, .acc_id_i, .acc_valid_i,
        .acc_ready_o, .acc_res_data_o, .acc_res_id_o, .acc_res_valid_o, .acc_res_ready_i,
        .burst_src_o, .burst_dst_o, .burst_len_o, .burst_valid_o, .burst_ready_i,
        .burst_done_i, .busy_o
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_resp(input dma_fe_pkg::acc_data_t exp_data, act_data,
                              input dma_fe_pkg::acc_id_t exp_id, act_id);
        if (exp_data !== act_data) begin
            abort_run($sformatf("Error at %0t: acc_res_data_o expected %h got %h",
                                $time, exp_data, act_data));
        end else if (exp_id !== act_id) begin
            abort_run($sformatf("Error at %0t: acc_res_id_o expected %h got %h",
                                $time, exp_id, act_id));
        end
    endtask

    task automatic check_burst(input dma_fe_pkg::addr_t exp_src, act_src, exp_dst, act_dst,
                               input dma_fe_pkg::len_t exp_len, act_len);
        if (exp_src !== act_src) begin
            abort_run($sformatf("Error at %0t: burst_src_o expected %h got %h",
                                $time, exp_src, act_src));
        end else if (exp_dst !== act_dst) begin
            abort_run($sformatf("Error at %0t: burst_dst_o expected %h got %h",
                                $time, exp_dst, act_dst));
        end else if (exp_len !== act_len) begin
            abort_run($sformatf("Error at %0t: burst_len_o expected %h got %h",
                                $time, exp_len, act_len));
        end
    endtask

    task automatic check_busy(input logic exp_busy, act_busy);
        if (exp_busy !== act_busy) begin
            abort_run($sformatf("Error at %0t: busy_o expected %b got %b",
                                $time, exp_busy, act_busy));
        end
    endtask

    // drive one instruction and track what it launches
    task automatic send_instr(input dma_fe_pkg::instr_t op, input dma_fe_pkg::acc_data_t a,
                              input dma_fe_pkg::acc_data_t b, input dma_fe_pkg::acc_id_t id,
                              input bit must_stall);
        dma_fe_pkg::cfg_t cfg;
        @(negedge clk_i);
        acc_op_i    = op;
        acc_arga_i  = a;
        acc_argb_i  = b;
        acc_id_i    = id;
        acc_valid_i = 1'b1;
        if (must_stall) begin
            repeat (20) begin
                @(posedge clk_i);
                if (acc_ready_o) begin
                    abort_run("an instruction was accepted while the DUT should stall it");
                end
            end
            @(negedge clk_i);
            hold_burst <= 1'b0;
            hold_res   <= 1'b0;
        end
        @(posedge clk_i);
        while (!acc_ready_o) @(posedge clk_i);
        if (op[2:0] == `DMA_OP_REP) begin
            model_reps = a[31:0];
        end else if (op[2:0] == `DMA_OP_CPY) begin
            cfg = op[`DMA_IMM_BIT] ? op[`DMA_CFG_LSB+1:`DMA_CFG_LSB] : b[1:0];
            launched++;
            job_bursts_q.push_back(cfg[1] ? ((model_reps == 0) ? 1 : int'(model_reps)) : 1);
        end
        @(negedge clk_i);
        acc_valid_i = 1'b0;
        // an accepted copy is still queued at this edge
        if (op[2:0] == `DMA_OP_CPY) begin
            check_busy(1'b1, busy_o);
        end
    endtask

    task automatic wait_quiet();
        while (exp_data_q.size() != 0 || exp_src_q.size() != 0 || owed != 0
               || job_bursts_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        check_busy(1'b0, busy_o);
    endtask

    //----------------------------------------------------------------------
    // monitors on the rising edge
    //----------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (arst_n_i && acc_res_valid_o && acc_res_ready_i) begin
            if (exp_data_q.size() == 0) begin
                abort_run("the DUT sent a response that no record expects");
            end else begin
                check_resp(exp_data_q.pop_front(), acc_res_data_o,
                           exp_id_q.pop_front(), acc_res_id_o);
            end
        end
    end

    always @(posedge clk_i) begin
        if (arst_n_i && burst_valid_o && burst_ready_i) begin
            if (exp_src_q.size() == 0) begin
                abort_run("the DUT issued a burst that no record expects");
            end else begin
                check_burst(exp_src_q.pop_front(), burst_src_o, exp_dst_q.pop_front(),
                            burst_dst_o, exp_len_q.pop_front(), burst_len_o);
                owed++;
            end
        end
    end

    // backend model, one done pulse per burst in order
    initial begin
        wait (arst_n_i === 1'b1);
        forever begin
            @(negedge clk_i);
            burst_done_i    = 1'b0;
            burst_ready_i   = hold_burst ? 1'b0 : (($random(seed) & 3) != 0);
            acc_res_ready_i = hold_res ? 1'b0 : (($random(seed) & 3) != 0);
            if (done_wait > 0) begin
                done_wait--;
            end else if (owed > 0) begin
                burst_done_i = 1'b1;
                owed--;
                job_done_cnt++;
                if (job_done_cnt == job_bursts_q[0]) begin
                    void'(job_bursts_q.pop_front());
                    jobs_done++;
                    job_done_cnt = 0;
                end
                done_wait = $random(seed) & 3;
            end
        end
    end

    initial begin
        wait (n_rec > 0);
        #(n_rec * 200 * 40);
        $display("timed out waiting for the DUT");
        $display("** FAIL **");
        $fatal(1);
    end

    //----------------------------------------------------------------------
    // record player
    //----------------------------------------------------------------------
    initial begin
        int i;
        logic [63:0] w [REC_W];
        seed = 32'h2f78;
        arst_n_i = 1'b0;
        acc_op_i = '0;
        acc_arga_i = '0;
        acc_argb_i = '0;
        acc_id_i = '0;
        acc_valid_i = 1'b0;
        acc_res_ready_i = 1'b0;
        burst_ready_i = 1'b0;
        burst_done_i = 1'b0;
        hold_burst = 1'b0;
        hold_res = 1'b0;
        owed = 0;
        done_wait = 0;
        job_done_cnt = 0;
        jobs_done = 0;
        launched = 0;
        model_reps = '0;
        $readmemh("sim/dma_fe_testdata.txt", recs);
        i = 0;
        while (i < MAX_REC && recs[i*REC_W] !== 64'hf) i++;
        n_rec = i;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        for (int r = 0; r < n_rec; r++) begin
            for (int k = 0; k < REC_W; k++) w[k] = recs[r*REC_W+k];
            case (w[0])
                64'h0: send_instr(w[1][31:0], w[2], w[3], w[4][4:0], 1'b0);
                64'h5: send_instr(w[1][31:0], w[2], w[3], w[4][4:0], 1'b1);
                64'h1: begin
                    // flag 1 is the count of finished jobs, flag 2 is busy
                    if (w[3] == 64'h1) begin
                        exp_data_q.push_back(64'(jobs_done));
                    end else if (w[3] == 64'h2) begin
                        exp_data_q.push_back(64'(launched != jobs_done));
                    end else begin
                        exp_data_q.push_back(w[1]);
                    end
                    exp_id_q.push_back(w[2][4:0]);
                end
                64'h2: begin
                    exp_src_q.push_back(w[1][47:0]);
                    exp_dst_q.push_back(w[2][47:0]);
                    exp_len_q.push_back(w[3][31:0]);
                end
                64'h3: begin
                    // earlier responses drain before the response path is held
                    while (w[2][0] && exp_data_q.size() != 0) @(posedge clk_i);
                    hold_burst <= w[1][0];
                    hold_res   <= w[2][0];
                end
                64'h4: wait_quiet();
                default: abort_run("the testdata file holds an unknown record kind");
            endcase
        end
        wait_quiet();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/dma_fe_top.sv
// top of the tightly coupled DMA frontend
// accelerator channel in, strided bursts out to an external backend
`timescale 1ns/1ps
`default_nettype none

module dma_fe_top (
    input  wire logic                  clk_i,
    input  wire logic                  arst_n_i,
    input  wire dma_fe_pkg::instr_t    acc_op_i,
    input  wire dma_fe_pkg::acc_data_t acc_arga_i,
    input  wire dma_fe_pkg::acc_data_t acc_argb_i,
    input  wire dma_fe_pkg::acc_id_t   acc_id_i,
    input  wire logic                  acc_valid_i,
    output logic                       acc_ready_o,
    output dma_fe_pkg::acc_data_t      acc_res_data_o,
    output dma_fe_pkg::acc_id_t        acc_res_id_o,
    output logic                       acc_res_valid_o,
    input  wire logic                  acc_res_ready_i,
    output dma_fe_pkg::addr_t          burst_src_o,
    output dma_fe_pkg::addr_t          burst_dst_o,
    output dma_fe_pkg::len_t           burst_len_o,
    output logic                       burst_valid_o,
    input  wire logic                  burst_ready_i,
    input  wire logic                  burst_done_i,
    output logic                       busy_o
);

    // decoder to queue
    dma_fe_pkg::addr_t     push_src, push_dst, job_src, job_dst;
    dma_fe_pkg::len_t      push_len, job_len;
    dma_fe_pkg::stride_t   push_src_stride, push_dst_stride, job_src_stride, job_dst_stride;
    dma_fe_pkg::rep_t      push_reps, job_reps;
    logic                  push_valid, push_ready, job_valid, job_ready;
    // response path and IDs
    dma_fe_pkg::acc_data_t res_data;
    dma_fe_pkg::acc_id_t   res_id;
    logic                  res_valid, res_ready;
    dma_fe_pkg::tf_id_t    next_id, completed_id;
    logic                  issue, retire, fifo_empty, midend_idle;

    assign issue  = push_valid & push_ready;
    assign busy_o = !fifo_empty | !midend_idle;

    //----------------------------------------------------------------------
    // decode, queue and 2D expansion
    //----------------------------------------------------------------------
    dma_inst_decode i_decode (
        .clk_i, .arst_n_i,
        .op_i (acc_op_i), .arga_i (acc_arga_i), .argb_i (acc_argb_i),
        .id_i (acc_id_i), .valid_i (acc_valid_i), .ready_o (acc_ready_o),
        .push_src_o (push_src), .push_dst_o (push_dst), .push_len_o (push_len),
        .push_src_stride_o (push_src_stride), .push_dst_stride_o (push_dst_stride),
        .push_reps_o (push_reps), .push_valid_o (push_valid), .push_ready_i (push_ready),
        .res_data_o (res_data), .res_id_o (res_id),
        .res_valid_o (res_valid), .res_ready_i (res_ready),
        .next_id_i (next_id), .completed_id_i (completed_id), .busy_i (busy_o)
    );

    dma_req_fifo i_req_fifo (
        .clk_i, .arst_n_i,
        .src_i (push_src), .dst_i (push_dst), .len_i (push_len),
        .src_stride_i (push_src_stride), .dst_stride_i (push_dst_stride),
        .reps_i (push_reps), .valid_i (push_valid), .ready_o (push_ready),
        .src_o (job_src), .dst_o (job_dst), .len_o (job_len),
        .src_stride_o (job_src_stride), .dst_stride_o (job_dst_stride),
        .reps_o (job_reps), .valid_o (job_valid), .ready_i (job_ready),
        .empty_o (fifo_empty)
    );

    dma_twod_midend i_midend (
        .clk_i, .arst_n_i,
        .job_src_i (job_src), .job_dst_i (job_dst), .job_len_i (job_len),
        .job_src_stride_i (job_src_stride), .job_dst_stride_i (job_dst_stride),
        .job_reps_i (job_reps), .job_valid_i (job_valid), .job_ready_o (job_ready),
        .burst_src_o, .burst_dst_o, .burst_len_o, .burst_valid_o, .burst_ready_i,
        .burst_done_i, .retire_o (retire), .idle_o (midend_idle)
    );

    //----------------------------------------------------------------------
    // IDs and response decoupling
    //----------------------------------------------------------------------
    dma_transfer_id_gen i_id_gen (
        .clk_i, .arst_n_i,
        .issue_i (issue), .retire_i (retire),
        .next_o (next_id), .completed_o (completed_id)
    );

    dma_resp_spill i_resp_spill (
        .clk_i, .arst_n_i,
        .data_i (res_data), .id_i (res_id), .valid_i (res_valid), .ready_o (res_ready),
        .data_o (acc_res_data_o), .id_o (acc_res_id_o),
        .valid_o (acc_res_valid_o), .ready_i (acc_res_ready_i)
    );

endmodule

`default_nettype wire

//--- design/dma_resp_spill.sv
// two-entry spill register on the accelerator response path
// output is registered, input ready while the spill slot is free
`timescale 1ns/1ps
`default_nettype none

module dma_resp_spill (
    input  wire logic                  clk_i,
    input  wire logic                  arst_n_i,
    input  wire dma_fe_pkg::acc_data_t data_i,
    input  wire dma_fe_pkg::acc_id_t   id_i,
    input  wire logic                  valid_i,
    output logic                       ready_o,
    output dma_fe_pkg::acc_data_t      data_o,
    output dma_fe_pkg::acc_id_t        id_o,
    output logic                       valid_o,
    input  wire logic                  ready_i
);

    dma_fe_pkg::acc_data_t spill_data_q;
    dma_fe_pkg::acc_id_t   spill_id_q;
    logic                  spill_full_q;
    logic                  in_fire, load_out;

    assign ready_o  = !spill_full_q;
    assign in_fire  = valid_i & ready_o;
    // output slot can take new data when empty or draining
    assign load_out = !valid_o | ready_i;

    always_ff @(posedge clk_i) begin
        if (load_out) begin
            data_o <= spill_full_q ? spill_data_q : data_i;
            id_o   <= spill_full_q ? spill_id_q : id_i;
        end else if (in_fire) begin
            spill_data_q <= data_i;
            spill_id_q   <= id_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o      <= 1'b0;
            spill_full_q <= 1'b0;
        end else if (load_out) begin
            valid_o      <= spill_full_q | in_fire;
            spill_full_q <= 1'b0;
        end else if (in_fire) begin
            spill_full_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/dma_transfer_id_gen.sv
// next and completed transfer ID counters, both wrap
`timescale 1ns/1ps
`default_nettype none

module dma_transfer_id_gen (
    input  wire logic          clk_i,
    input  wire logic          arst_n_i,
    input  wire logic          issue_i,
    input  wire logic          retire_i,
    output dma_fe_pkg::tf_id_t next_o,
    output dma_fe_pkg::tf_id_t completed_o
);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            next_o      <= '0;
            completed_o <= '0;
        end else begin
            next_o      <= next_o + dma_fe_pkg::tf_id_t'(issue_i);
            completed_o <= completed_o + dma_fe_pkg::tf_id_t'(retire_i);
        end
    end

    // a retire always belongs to an issued job
    a_no_overtake: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        retire_i |-> completed_o != next_o);

endmodule

`default_nettype wire

//--- design/dma_twod_midend.sv
// 2D midend: expands one job into reps strided bursts
// retires the job once every burst has reported done
`timescale 1ns/1ps
`default_nettype none

module dma_twod_midend (
    input  wire logic                clk_i,
    input  wire logic                arst_n_i,
    input  wire dma_fe_pkg::addr_t   job_src_i,
    input  wire dma_fe_pkg::addr_t   job_dst_i,
    input  wire dma_fe_pkg::len_t    job_len_i,
    input  wire dma_fe_pkg::stride_t job_src_stride_i,
    input  wire dma_fe_pkg::stride_t job_dst_stride_i,
    input  wire dma_fe_pkg::rep_t    job_reps_i,
    input  wire logic                job_valid_i,
    output logic                     job_ready_o,
    output dma_fe_pkg::addr_t        burst_src_o,
    output dma_fe_pkg::addr_t        burst_dst_o,
    output dma_fe_pkg::len_t         burst_len_o,
    output logic                     burst_valid_o,
    input  wire logic                burst_ready_i,
    input  wire logic                burst_done_i,
    output logic                     retire_o,
    output logic                     idle_o
);

    dma_fe_pkg::midend_state_e state_q;
    dma_fe_pkg::addr_t         src_q, dst_q;
    dma_fe_pkg::len_t          len_q;
    dma_fe_pkg::stride_t       src_stride_q, dst_stride_q;
    dma_fe_pkg::rep_t          reps_q, issue_cnt_q, done_cnt_q;
    logic                      take, burst_fire;

    assign idle_o        = (state_q == dma_fe_pkg::IDLE);
    assign job_ready_o   = idle_o;
    assign take          = job_valid_i & job_ready_o;
    assign burst_valid_o = (state_q == dma_fe_pkg::ISSUE);
    assign burst_fire    = burst_valid_o & burst_ready_i;
    assign retire_o      = (state_q == dma_fe_pkg::WAIT) && (done_cnt_q == reps_q);

    assign burst_src_o = src_q;
    assign burst_dst_o = dst_q;
    assign burst_len_o = len_q;

    // running addresses and job payload
    always_ff @(posedge clk_i) begin
        if (take) begin
            src_q        <= job_src_i;
            dst_q        <= job_dst_i;
            len_q        <= job_len_i;
            src_stride_q <= job_src_stride_i;
            dst_stride_q <= job_dst_stride_i;
        end else if (burst_fire) begin
            src_q <= src_q + dma_fe_pkg::addr_t'(src_stride_q);
            dst_q <= dst_q + dma_fe_pkg::addr_t'(dst_stride_q);
        end
    end

    //----------------------------------------------------------------------
    // FSM and burst counters
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= dma_fe_pkg::IDLE;
            reps_q      <= '0;
            issue_cnt_q <= '0;
            done_cnt_q  <= '0;
        end else begin
            if (burst_done_i) begin
                done_cnt_q <= done_cnt_q + 1'b1;
            end
            case (state_q)
                dma_fe_pkg::IDLE: if (take) begin
                    // zero reps still moves one burst
                    reps_q      <= (job_reps_i == '0) ? dma_fe_pkg::rep_t'(1) : job_reps_i;
                    issue_cnt_q <= '0;
                    done_cnt_q  <= '0;
                    state_q     <= dma_fe_pkg::ISSUE;
                end
                dma_fe_pkg::ISSUE: if (burst_fire) begin
                    issue_cnt_q <= issue_cnt_q + 1'b1;
                    if (issue_cnt_q + 1'b1 == reps_q) begin
                        state_q <= dma_fe_pkg::WAIT;
                    end
                end
                default: if (retire_o) begin
                    issue_cnt_q <= '0;
                    done_cnt_q  <= '0;
                    state_q     <= dma_fe_pkg::IDLE;
                end
            endcase
        end
    end

    // backend never reports more bursts than were handed to it
    a_done_owed: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        burst_done_i |-> done_cnt_q != issue_cnt_q);

endmodule

`default_nettype wire

//--- design/dma_req_fifo.sv
// circular queue of launched jobs between decoder and midend
// depth comes from the macros header
`timescale 1ns/1ps
`default_nettype none

`include "dma_fe_macros.svh"

module dma_req_fifo (
    input  wire logic                clk_i,
    input  wire logic                arst_n_i,
    input  wire dma_fe_pkg::addr_t   src_i,
    input  wire dma_fe_pkg::addr_t   dst_i,
    input  wire dma_fe_pkg::len_t    len_i,
    input  wire dma_fe_pkg::stride_t src_stride_i,
    input  wire dma_fe_pkg::stride_t dst_stride_i,
    input  wire dma_fe_pkg::rep_t    reps_i,
    input  wire logic                valid_i,
    output logic                     ready_o,
    output dma_fe_pkg::addr_t        src_o,
    output dma_fe_pkg::addr_t        dst_o,
    output dma_fe_pkg::len_t         len_o,
    output dma_fe_pkg::stride_t      src_stride_o,
    output dma_fe_pkg::stride_t      dst_stride_o,
    output dma_fe_pkg::rep_t         reps_o,
    output logic                     valid_o,
    input  wire logic                ready_i,
    output logic                     empty_o
);

    localparam int unsigned DEPTH = `DMA_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);
    localparam int unsigned JOB_W = 2 * `DMA_ADDR_WIDTH + `DMA_LEN_WIDTH + 3 * `DMA_REP_WIDTH;

    logic [JOB_W-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push, pop;

    assign ready_o = (count_q != CNT_W'(DEPTH));
    assign valid_o = (count_q != '0);
    assign empty_o = (count_q == '0);
    assign push    = valid_i & ready_o;
    assign pop     = valid_o & ready_i;

    assign {src_o, dst_o, len_o, src_stride_o, dst_stride_o, reps_o} = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= {src_i, dst_i, len_i, src_stride_i, dst_stride_i, reps_i};
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // write side stays exactly count entries ahead, so a push when full breaks it
    a_ptr_in_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        int'(wr_ptr_q) == (int'(rd_ptr_q) + int'(count_q)) % DEPTH);

endmodule

`default_nettype wire

//--- design/dma_inst_decode.sv
// decodes DMA instructions from the accelerator request channel
// holds the job config registers, pushes jobs and composes responses
`timescale 1ns/1ps
`default_nettype none

`include "dma_fe_macros.svh"

module dma_inst_decode (
    input  wire logic                 clk_i,
    input  wire logic                 arst_n_i,
    input  wire dma_fe_pkg::instr_t   op_i,
    input  wire dma_fe_pkg::acc_data_t arga_i,
    input  wire dma_fe_pkg::acc_data_t argb_i,
    input  wire dma_fe_pkg::acc_id_t  id_i,
    input  wire logic                 valid_i,
    output logic                      ready_o,
    output dma_fe_pkg::addr_t         push_src_o,
    output dma_fe_pkg::addr_t         push_dst_o,
    output dma_fe_pkg::len_t          push_len_o,
    output dma_fe_pkg::stride_t       push_src_stride_o,
    output dma_fe_pkg::stride_t       push_dst_stride_o,
    output dma_fe_pkg::rep_t          push_reps_o,
    output logic                      push_valid_o,
    input  wire logic                 push_ready_i,
    output dma_fe_pkg::acc_data_t     res_data_o,
    output dma_fe_pkg::acc_id_t       res_id_o,
    output logic                      res_valid_o,
    input  wire logic                 res_ready_i,
    input  wire dma_fe_pkg::tf_id_t   next_id_i,
    input  wire dma_fe_pkg::tf_id_t   completed_id_i,
    input  wire logic                 busy_i
);

    dma_fe_pkg::addr_t   src_q, dst_q;
    dma_fe_pkg::stride_t src_stride_q, dst_stride_q;
    dma_fe_pkg::rep_t    reps_q;
    dma_fe_pkg::cfg_t    cfg;
    logic [2:0]          opcode;

    assign opcode = op_i[2:0];
    // immediate form takes the selector from the instruction word
    assign cfg = op_i[`DMA_IMM_BIT] ? op_i[`DMA_CFG_LSB+1:`DMA_CFG_LSB] : argb_i[1:0];

    // job fields, 2D bit clear means a single burst
    assign push_src_o        = src_q;
    assign push_dst_o        = dst_q;
    assign push_len_o        = arga_i[`DMA_LEN_WIDTH-1:0];
    assign push_src_stride_o = src_stride_q;
    assign push_dst_stride_o = dst_stride_q;
    assign push_reps_o       = cfg[1] ? reps_q : dma_fe_pkg::rep_t'(1);

    //----------------------------------------------------------------------
    // decode and handshakes
    //----------------------------------------------------------------------
    always_comb begin
        ready_o      = 1'b0;
        push_valid_o = 1'b0;
        res_valid_o  = 1'b0;
        res_id_o     = id_i;
        res_data_o   = '0;
        if (valid_i) begin
            case (opcode)
                `DMA_OP_SRC, `DMA_OP_DST, `DMA_OP_STR, `DMA_OP_REP: ready_o = 1'b1;
                `DMA_OP_CPY: begin
                    // launch only when both the queue and the response path can take it
                    push_valid_o = res_ready_i;
                    ready_o      = res_ready_i & push_ready_i;
                    res_valid_o  = res_ready_i & push_ready_i;
                    res_data_o   = dma_fe_pkg::acc_data_t'(next_id_i);
                end
                `DMA_OP_STAT: begin
                    ready_o     = res_ready_i;
                    res_valid_o = res_ready_i;
                    case (cfg)
                        2'd0:    res_data_o = dma_fe_pkg::acc_data_t'(completed_id_i);
                        2'd1:    res_data_o = dma_fe_pkg::acc_data_t'(next_id_i);
                        2'd2:    res_data_o = dma_fe_pkg::acc_data_t'(busy_i);
                        default: res_data_o = dma_fe_pkg::acc_data_t'(!push_ready_i);
                    endcase
                end
                default: ready_o = 1'b0;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // config registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            src_q        <= '0;
            dst_q        <= '0;
            src_stride_q <= '0;
            dst_stride_q <= '0;
            reps_q       <= '0;
        end else if (valid_i) begin
            // address is arga[31:0] with argb[15:0] on top
            case (opcode)
                `DMA_OP_SRC: src_q <= {argb_i[15:0], arga_i[31:0]};
                `DMA_OP_DST: dst_q <= {argb_i[15:0], arga_i[31:0]};
                `DMA_OP_STR: begin
                    src_stride_q <= arga_i[`DMA_REP_WIDTH-1:0];
                    dst_stride_q <= argb_i[`DMA_REP_WIDTH-1:0];
                end
                `DMA_OP_REP: reps_q <= arga_i[`DMA_REP_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // the core holds a stalled instruction
    a_op_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i && !ready_o |=> valid_i && $stable(op_i) && $stable(id_i));

endmodule

`default_nettype wire

//--- design/dma_fe_pkg.sv
// shared types of the tightly coupled DMA frontend
// modules refer to these by scoped name
`default_nettype none

`include "dma_fe_macros.svh"

package dma_fe_pkg;

    // addresses and transfer sizes
    typedef logic [`DMA_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`DMA_LEN_WIDTH-1:0]    len_t;
    typedef logic [`DMA_REP_WIDTH-1:0]    rep_t;
    // added modulo 2^48 to the running address
    typedef logic [`DMA_REP_WIDTH-1:0]    stride_t;
    typedef logic [`DMA_TFID_WIDTH-1:0]   tf_id_t;

    // accelerator channel
    typedef logic [`DMA_DATA_WIDTH-1:0]   acc_data_t;
    typedef logic [`DMA_ACC_ID_WIDTH-1:0] acc_id_t;
    typedef logic [31:0]                  instr_t;
    typedef logic [1:0]                   cfg_t;

    // 2D midend FSM
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT
    } midend_state_e;

endpackage

`default_nettype wire

//--- design/dma_fe_macros.svh
// widths, opcodes and instruction field positions of the DMA frontend
// included by the package and by every module that sizes or decodes things
`ifndef DMA_FE_MACROS_SVH
`define DMA_FE_MACROS_SVH

`define DMA_ADDR_WIDTH   48
`define DMA_DATA_WIDTH   64
`define DMA_LEN_WIDTH    32
`define DMA_REP_WIDTH    32
`define DMA_TFID_WIDTH   32
`define DMA_ACC_ID_WIDTH 5
`define DMA_FIFO_DEPTH   3

// opcodes in instruction bits 2..0
`define DMA_OP_SRC  3'd0
`define DMA_OP_DST  3'd1
`define DMA_OP_CPY  3'd2
`define DMA_OP_STAT 3'd3
`define DMA_OP_STR  3'd4
`define DMA_OP_REP  3'd5

// immediate form select and immediate config field (bits 21..20)
`define DMA_IMM_BIT 3
`define DMA_CFG_LSB 20

`endif
